//--- flist.f
lcd_pkg.sv
lcd_delay_timer.sv
lcd_nibble_writer.sv
lcd_sequencer.sv
lcd_controller_top.sv
lcd_bus_asserts.sv
tb_lcd_controller.sv

//--- lcd_bus_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_bus_asserts #(
    parameter int EN_MIN = 1  // Minimum EN high time in cycles
) (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire lcd_pkg::lcd_bus_t lcd,
    input wire logic              done
);

    int en_high_cyc;  // Length of the current EN pulse so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            en_high_cyc <= 0;
        else if (lcd.en)
            en_high_cyc <= en_high_cyc + 1;
        else
            en_high_cyc <= 0;
    end

    en_pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(lcd.en) |-> en_high_cyc >= EN_MIN)
        else $error("EN pulse shorter than %0d cycles", EN_MIN);

    // Display samples RS and DATA while EN is high
    bus_stable_en: assert property (@(posedge clk) disable iff (!rst_n)
        lcd.en && $past(lcd.en) |-> $stable({lcd.rs, lcd.data}))
        else $error("RS or DATA changed while EN was high");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !lcd.en && !done)
        else $error("EN or done active during reset");

endmodule

`default_nettype wire

//--- lcd_controller_top.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_controller_top #(
    parameter int CLK_FREQ_HZ = 50_000_000,
    parameter int SETUP_NS    = 100,
    parameter int EN_PULSE_NS = 500
) (
    input  logic               clk,
    input  logic               rst_n,
    output lcd_pkg::lcd_bus_t  lcd,
    output logic               done
);

    logic                 wr_start;
    logic                 wr_done;
    lcd_pkg::lcd_req_t    wr_req;
    logic                 tmr_start;
    logic                 tmr_done;
    lcd_pkg::lcd_delay_e  tmr_sel;

    lcd_sequencer seq_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_start  (wr_start),
        .wr_req    (wr_req),
        .wr_done   (wr_done),
        .tmr_start (tmr_start),
        .tmr_sel   (tmr_sel),
        .tmr_done  (tmr_done),
        .done      (done)
    );

    lcd_delay_timer #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ)
    ) tmr_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (tmr_start),
        .sel   (tmr_sel),
        .done  (tmr_done)
    );

    lcd_nibble_writer #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .SETUP_NS    (SETUP_NS),
        .EN_PULSE_NS (EN_PULSE_NS)
    ) wr_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (wr_start),
        .req   (wr_req),
        .lcd   (lcd),
        .done  (wr_done)
    );

endmodule

`default_nettype wire

//--- lcd_delay_timer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_delay_timer #(
    parameter int CLK_FREQ_HZ = 50_000_000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  lcd_pkg::lcd_delay_e    sel,
    output logic                   done
);

    lcd_pkg::lcd_cycles_t cnt;    // Cycles left before done
    lcd_pkg::lcd_cycles_t load_n; // Full count for sel

    // Microseconds to cycles, rounded down, never below one
    function automatic lcd_pkg::lcd_cycles_t delay_cycles(input lcd_pkg::lcd_delay_e d);
        longint us;
        longint n;
        case (d)
            lcd_pkg::DLY_POWERUP: us = 15_000;
            lcd_pkg::DLY_4MS1:    us = 4_100;
            lcd_pkg::DLY_100US:   us = 100;
            lcd_pkg::DLY_1MS6:    us = 1_600;
            default:              us = 40;
        endcase
        n = longint'(CLK_FREQ_HZ) * us / 64'd1_000_000;
        if (n < 1)
            n = 1;
        return lcd_pkg::lcd_cycles_t'(n);
    endfunction

    assign load_n = delay_cycles(sel);

    // done lands exactly load_n cycles after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (start) begin
            cnt  <= load_n - 1'b1;
            done <= (load_n == 1);  // Shortest delay fires next cycle
        end else if (cnt != 0) begin
            cnt  <= cnt - 1'b1;
            done <= (cnt == 1);
        end else begin
            done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- lcd_nibble_writer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_nibble_writer #(
    parameter int CLK_FREQ_HZ = 50_000_000,
    parameter int SETUP_NS    = 100,
    parameter int EN_PULSE_NS = 500
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  lcd_pkg::lcd_req_t  req,
    output lcd_pkg::lcd_bus_t  lcd,
    output logic               done
);

    // Phase lengths, one extra cycle to cover truncation
    localparam lcd_pkg::lcd_cycles_t SETUP_CYC =
        lcd_pkg::lcd_cycles_t'(longint'(CLK_FREQ_HZ) * SETUP_NS / 64'd1_000_000_000 + 1);
    localparam lcd_pkg::lcd_cycles_t EN_CYC =
        lcd_pkg::lcd_cycles_t'(longint'(CLK_FREQ_HZ) * EN_PULSE_NS / 64'd1_000_000_000 + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,
        S_EN_HIGH,
        S_EN_LOW
    } wr_state_e;

    wr_state_e            state;
    lcd_pkg::lcd_cycles_t cnt;          // Cycles left in the current phase
    logic                 low_nib;      // Second nibble of a byte in progress
    logic                 nibble_only_q;
    lcd_pkg::lcd_byte_t   value_q;
    logic                 last_nib;

    assign last_nib = nibble_only_q || low_nib;

    // Pulse in the final EN low cycle of the write
    assign done = (state == S_EN_LOW) && (cnt == 0) && last_nib;

    // Request held for the low nibble
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            value_q       <= req.value;
            nibble_only_q <= req.nibble_only;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            cnt     <= '0;
            low_nib <= 1'b0;
            lcd     <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        lcd.rs   <= req.rs;
                        lcd.data <= req.value[7:4];  // High nibble first
                        cnt      <= SETUP_CYC - 1'b1;
                        low_nib  <= 1'b0;
                        state    <= S_SETUP;
                    end
                end
                S_SETUP: begin
                    if (cnt == 0) begin
                        lcd.en <= 1'b1;
                        cnt    <= EN_CYC - 1'b1;
                        state  <= S_EN_HIGH;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_EN_HIGH: begin
                    if (cnt == 0) begin
                        lcd.en <= 1'b0;  // Display latches on this edge
                        cnt    <= EN_CYC - 1'b1;
                        state  <= S_EN_LOW;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_EN_LOW: begin
                    if (cnt != 0) begin
                        cnt <= cnt - 1'b1;
                    end else if (last_nib) begin
                        lcd.rs   <= 1'b0;
                        lcd.data <= '0;
                        state    <= S_IDLE;
                    end else begin
                        lcd.data <= value_q[3:0];
                        low_nib  <= 1'b1;
                        cnt      <= SETUP_CYC - 1'b1;
                        state    <= S_SETUP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    typedef logic [3:0]  lcd_nibble_t;  // One nibble on DB7..DB4
    typedef logic [7:0]  lcd_byte_t;    // Instruction or character code
    typedef logic [31:0] lcd_cycles_t;  // Clock cycle count

    // Wait that follows an item on the bus
    typedef enum logic [2:0] {
        DLY_POWERUP,  // 15 ms
        DLY_4MS1,     // 4.1 ms
        DLY_100US,    // 100 us
        DLY_40US,     // 40 us
        DLY_1MS6      // 1.6 ms
    } lcd_delay_e;

    // Display pins
    typedef struct packed {
        logic        rs;
        logic        en;
        lcd_nibble_t data;
    } lcd_bus_t;

    // One write to the display
    typedef struct packed {
        logic      rs;
        logic      nibble_only;  // Only value[7:4] goes out
        lcd_byte_t value;
    } lcd_req_t;

    localparam lcd_byte_t CMD_FUNC_SET = 8'h28;  // 4-bit bus, 2 lines, 5x8 font
    localparam lcd_byte_t CMD_DISP_OFF = 8'h08;
    localparam lcd_byte_t CMD_CLEAR    = 8'h01;
    localparam lcd_byte_t CMD_ENTRY    = 8'h06;  // Increment, no shift
    localparam lcd_byte_t CMD_DISP_ON  = 8'h0C;  // Cursor and blink off
    localparam lcd_byte_t CMD_DDRAM0   = 8'h80;

    // Wake-up nibbles, sent while the display may still be in 8-bit mode
    localparam lcd_nibble_t WAKE_NIBBLE     = 4'h3;
    localparam lcd_nibble_t SET_4BIT_NIBBLE = 4'h2;

    localparam int MSG_LEN = 10;

    localparam lcd_byte_t MESSAGE [MSG_LEN] = '{
        "H", "E", "L", "L", "O", " ", "L", "C", "D", "!"
    };

endpackage

`default_nettype wire

//--- lcd_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 wr_start,
    output lcd_pkg::lcd_req_t    wr_req,
    input  logic                 wr_done,
    output logic                 tmr_start,
    output lcd_pkg::lcd_delay_e  tmr_sel,
    input  logic                 tmr_done,
    output logic                 done
);

    // Item list: 4 wake nibbles, 6 commands, then the message
    localparam int NUM_WAKE  = 4;
    localparam int NUM_INIT  = NUM_WAKE + 6;
    localparam int NUM_ITEMS = NUM_INIT + lcd_pkg::MSG_LEN;
    localparam int IDX_W     = $clog2(NUM_ITEMS + 1);

    typedef enum logic [2:0] {
        ST_BOOT,
        ST_POWERUP,
        ST_WRITE_WAIT,
        ST_DELAY_WAIT,
        ST_FINISHED
    } seq_state_e;

    seq_state_e       state;
    logic [IDX_W-1:0] item_idx;  // Next item to write

    function automatic lcd_pkg::lcd_req_t item_req(input logic [IDX_W-1:0] idx);
        lcd_pkg::lcd_req_t r;
        int                msg_idx;
        msg_idx       = int'(idx) - NUM_INIT;
        r.rs          = 1'b0;
        r.nibble_only = 1'b0;
        r.value       = '0;
        case (int'(idx))
            0, 1, 2: begin
                r.nibble_only = 1'b1;
                r.value       = {lcd_pkg::WAKE_NIBBLE, 4'h0};
            end
            3: begin
                r.nibble_only = 1'b1;
                r.value       = {lcd_pkg::SET_4BIT_NIBBLE, 4'h0};
            end
            4: r.value = lcd_pkg::CMD_FUNC_SET;
            5: r.value = lcd_pkg::CMD_DISP_OFF;
            6: r.value = lcd_pkg::CMD_CLEAR;
            7: r.value = lcd_pkg::CMD_ENTRY;
            8: r.value = lcd_pkg::CMD_DISP_ON;
            9: r.value = lcd_pkg::CMD_DDRAM0;
            default: begin
                r.rs    = 1'b1;  // Character data
                r.value = lcd_pkg::MESSAGE[msg_idx];
            end
        endcase
        return r;
    endfunction

    // Execution time of each item
    function automatic lcd_pkg::lcd_delay_e item_delay(input logic [IDX_W-1:0] idx);
        case (int'(idx))
            0:       return lcd_pkg::DLY_4MS1;
            1, 2, 3: return lcd_pkg::DLY_100US;
            6:       return lcd_pkg::DLY_1MS6;  // Clear is the slow one
            default: return lcd_pkg::DLY_40US;
        endcase
    endfunction

    // Payload, only looked at together with its start pulse
    always_ff @(posedge clk) begin
        if (state == ST_POWERUP)
            tmr_sel <= lcd_pkg::DLY_POWERUP;
        else if (state == ST_WRITE_WAIT && wr_done)
            tmr_sel <= item_delay(item_idx);
        if (state == ST_DELAY_WAIT && tmr_done)
            wr_req <= item_req(item_idx);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_BOOT;
            item_idx  <= '0;
            wr_start  <= 1'b0;
            tmr_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            wr_start  <= 1'b0;
            tmr_start <= 1'b0;
            case (state)
                ST_BOOT: state <= ST_POWERUP;
                ST_POWERUP: begin
                    tmr_start <= 1'b1;
                    state     <= ST_DELAY_WAIT;
                end
                ST_DELAY_WAIT: begin
                    if (tmr_done) begin
                        if (int'(item_idx) == NUM_ITEMS) begin
                            done  <= 1'b1;
                            state <= ST_FINISHED;
                        end else begin
                            wr_start <= 1'b1;
                            state    <= ST_WRITE_WAIT;
                        end
                    end
                end
                ST_WRITE_WAIT: begin
                    if (wr_done) begin
                        tmr_start <= 1'b1;
                        item_idx  <= item_idx + 1'b1;
                        state     <= ST_DELAY_WAIT;
                    end
                end
                ST_FINISHED: done <= 1'b1;  // Parked until reset
                default:     state <= ST_BOOT;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the LCD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lcd_controller -f flist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

//--- tb_lcd_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lcd_controller;

    localparam int CLK_FREQ_HZ = 1_000_000;
    localparam int US          = CLK_FREQ_HZ / 1_000_000;  // Cycles per microsecond
    localparam int GAP_4MS1    = 4_100 * US;
    localparam int GAP_100US   = 100 * US;
    localparam int GAP_1MS6    = 1_600 * US;
    // Power-up, wake-up, clear and fifteen 40 us waits, plus write overhead
    localparam int RUN_CYCLES  = (15_000 + 4_100 + 3 * 100 + 1_600 + 15 * 40) * US + 400;
    // Two full runs, one partial run and the idle window
    localparam int TIMEOUT_CYCLES = 3 * RUN_CYCLES + 1_000 + 3_000;

    logic              clk;
    logic              rst_n;
    lcd_pkg::lcd_bus_t lcd;
    logic              done;

    int         cycle = 0;
    logic       en_q  = 1'b0;
    logic [4:0] cap_q[$];  // {rs, nibble} at each EN fall
    int         cap_t[$];  // Cycle of each EN fall
    logic [4:0] exp_q[$];

    lcd_controller_top #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ)
    ) dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .lcd   (lcd),
        .done  (done)
    );

    bind lcd_nibble_writer lcd_bus_asserts #(
        .EN_MIN (int'(EN_CYC))
    ) bus_chk_i (
        .clk   (clk),
        .rst_n (rst_n),
        .lcd   (lcd),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES)
            fail_run($sformatf("Timeout: tests did not finish within %0d cycles", cycle));
    end

    // Bus monitor, the display latches on the falling edge of EN
    always @(negedge clk) begin
        en_q <= lcd.en;
        if (en_q && !lcd.en) begin
            cap_q.push_back({lcd.rs, lcd.data});
            cap_t.push_back(cycle);
        end
    end

    function automatic void push_byte(input logic rs, input lcd_pkg::lcd_byte_t b);
        exp_q.push_back({rs, b[7:4]});
        exp_q.push_back({rs, b[3:0]});
    endfunction

    // Expected nibble stream from the display init rules
    function automatic void build_expected();
        exp_q.delete();
        repeat (3) exp_q.push_back({1'b0, lcd_pkg::WAKE_NIBBLE});
        exp_q.push_back({1'b0, lcd_pkg::SET_4BIT_NIBBLE});
        push_byte(1'b0, lcd_pkg::CMD_FUNC_SET);
        push_byte(1'b0, lcd_pkg::CMD_DISP_OFF);
        push_byte(1'b0, lcd_pkg::CMD_CLEAR);
        push_byte(1'b0, lcd_pkg::CMD_ENTRY);
        push_byte(1'b0, lcd_pkg::CMD_DISP_ON);
        push_byte(1'b0, lcd_pkg::CMD_DDRAM0);
        for (int i = 0; i < lcd_pkg::MSG_LEN; i++)
            push_byte(1'b1, lcd_pkg::MESSAGE[i]);
    endfunction

    task automatic wait_captures(input int n);
        while (cap_q.size() < n)
            @(negedge clk);
    endtask

    // Returns just after a rising edge that leaves a nonzero nibble on the bus
    task automatic wait_data_on_bus();
        @(posedge clk);
        #1;
        while (lcd.data == '0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Gap check that shows the real gap when it falls short
    task automatic check_gap(input string name, input int idx, input int min_cyc);
        int gap;
        gap = cap_t[idx] - cap_t[idx - 1];
        check_eq(name, 32'((gap >= min_cyc) ? min_cyc : gap), 32'(min_cyc));
    endtask

    // Rebuild {rs, byte} from two captured nibbles
    task automatic check_bytes(input string what, input int first, input int nbytes);
        int p;
        for (int k = 0; k < nbytes; k++) begin
            p = first + 2 * k;
            check_eq($sformatf("%s %0d", what, k), 32'({cap_q[p], cap_q[p + 1]}),
                     32'({exp_q[p], exp_q[p + 1]}));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_eq("lcd in reset", 32'(lcd), 32'(0));
            check_eq("done in reset", 32'(done), 32'(0));
        end
        @(posedge clk);
        #1 rst_n = 1'b1;
        cap_q.delete();  // Drops any edge caused by the reset itself
        cap_t.delete();
        @(negedge clk);
        check_eq("lcd after reset", 32'(lcd), 32'(0));
        check_eq("done after reset", 32'(done), 32'(0));
    endtask

    task automatic check_wakeup();
        wait_captures(4);
        for (int i = 0; i < 4; i++)
            check_eq($sformatf("wake nibble %0d", i), 32'(cap_q[i]), 32'(exp_q[i]));
        check_gap("gap after wake nibble 0", 1, GAP_4MS1);
        check_gap("gap after wake nibble 1", 2, GAP_100US);
        check_gap("gap after wake nibble 2", 3, GAP_100US);
    endtask

    task automatic check_commands();
        wait_captures(16);
        check_bytes("command", 4, 6);
        check_gap("gap after clear", 10, GAP_1MS6);
    endtask

    task automatic check_message();
        wait_captures(36);
        check_bytes("character", 16, lcd_pkg::MSG_LEN);
        check_eq("done at last character", 32'(done), 32'(0));
        while (done !== 1'b1)
            @(negedge clk);
        check_eq("captures at done", 32'(cap_q.size()), 32'(36));
    endtask

    task automatic check_idle();
        repeat (1000) begin
            @(negedge clk);
            check_eq("lcd when idle", 32'(lcd), 32'(0));
            check_eq("done when idle", 32'(done), 32'(1));
        end
        check_eq("captures when idle", 32'(cap_q.size()), 32'(36));
    endtask

    initial begin
        rst_n = 1'b0;
        build_expected();
        apply_reset();
        check_wakeup();
        check_commands();
        check_message();
        check_idle();
        // Restart, then reset in the middle of the clear command write
        apply_reset();
        wait_captures(8);
        wait_data_on_bus();
        apply_reset();
        check_wakeup();
        check_commands();
        check_message();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
